// ==== hw/trace_pkg.sv ====
// Shared widths and the stage enum for the pipeline tracer
// Cycle stamps and the log counters wrap, the stall count saturates
// LOG_DEPTH_DEF is the default log depth and must stay a power of two

package trace_pkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////
  typedef logic [7:0]  tag_t;        // Tag the CPU gives a fetched instruction
  typedef logic [15:0] cycle_t;      // Free-running cycle stamp, wraps
  typedef logic [5:0]  stall_cnt_t;  // Stall cycles in IF and ID, saturates
  typedef logic [15:0] count_t;      // Retired and flushed totals, wrap
  typedef logic [2:0]  occ_t;        // Valid slots, 0 to 5

  ////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////
  // Also the slot index in the tracker, so order matters
  typedef enum logic [2:0] {
    ST_IF  = 3'd0,  // Fetch
    ST_ID  = 3'd1,  // Decode
    ST_EX  = 3'd2,  // Execute
    ST_MEM = 3'd3,  // Memory
    ST_WB  = 3'd4   // Writeback
  } stage_t;

  // Default retire log depth in records
  localparam int LOG_DEPTH_DEF = 8;

endpackage

// ==== hw/stage_tracker.sv ====
// Tracks one instruction per stage of a five-stage in-order pipeline
// Flush wins over stall; fetch_valid is only taken when neither is high
// Stall holds IF and ID and bubbles EX, MEM and WB always advance
// Retire outputs come straight from the WB slot, one cycle per instruction
// Stall counts saturate at the stall_cnt_t maximum

`timescale 1ns/10ps

module stage_tracker import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_valid,         // Instruction offered to IF this cycle
  input  tag_t       fetch_tag,
  input  logic       stall,               // Hold IF and ID
  input  logic       flush,               // Kill IF and ID
  output occ_t       occupancy,           // Valid slots right now
  output logic       retire_valid,        // WB holds a valid instruction
  output tag_t       retire_tag,
  output cycle_t     retire_fetch_cycle,
  output cycle_t     retire_cycle,
  output stall_cnt_t retire_stall_cnt,
  output logic [1:0] flush_kill_cnt       // Valid slots killed by this flush
);

  ////////////////////////////////////////////////////////////
  // Slot storage, one entry per stage
  ////////////////////////////////////////////////////////////
  logic       slot_valid [ST_IF:ST_WB];
  tag_t       slot_tag   [ST_IF:ST_WB];
  cycle_t     slot_fc    [ST_IF:ST_WB];   // Fetch stamp
  stall_cnt_t slot_sc    [ST_IF:ST_WB];   // Stall cycles so far

  cycle_t cycle_cnt;                      // Free-running stamp source
  logic   advance;                        // Front end moves this edge
  logic   hold;                           // Front end held by stall

  assign advance = !flush && !stall;
  assign hold    = !flush && stall;

  ////////////////////////////////////////////////////////////
  // Cycle counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;                    // Reads 0 in the first cycle after reset
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;      // Wraps at 2^16
    end
  end

  ////////////////////////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = ST_IF; s <= ST_WB; s++) begin
        slot_valid[s] <= 1'b0;
      end
    end else begin
      // Back end never waits
      slot_valid[ST_WB]  <= slot_valid[ST_MEM];
      slot_valid[ST_MEM] <= slot_valid[ST_EX];
      if (flush) begin
        slot_valid[ST_IF] <= 1'b0;        // Killed, fetch_valid ignored
        slot_valid[ST_ID] <= 1'b0;        // Killed
        slot_valid[ST_EX] <= 1'b0;        // Bubble in
      end else if (stall) begin
        slot_valid[ST_EX] <= 1'b0;        // Bubble in, IF and ID hold
      end else begin
        slot_valid[ST_EX] <= slot_valid[ST_ID];
        slot_valid[ST_ID] <= slot_valid[ST_IF];
        slot_valid[ST_IF] <= fetch_valid; // New instruction or bubble
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Slot payload
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    slot_tag[ST_WB]  <= slot_tag[ST_MEM];
    slot_fc[ST_WB]   <= slot_fc[ST_MEM];
    slot_sc[ST_WB]   <= slot_sc[ST_MEM];
    slot_tag[ST_MEM] <= slot_tag[ST_EX];
    slot_fc[ST_MEM]  <= slot_fc[ST_EX];
    slot_sc[ST_MEM]  <= slot_sc[ST_EX];

    if (advance) begin
      slot_tag[ST_EX] <= slot_tag[ST_ID];
      slot_fc[ST_EX]  <= slot_fc[ST_ID];
      slot_sc[ST_EX]  <= slot_sc[ST_ID];
      slot_tag[ST_ID] <= slot_tag[ST_IF];
      slot_fc[ST_ID]  <= slot_fc[ST_IF];
      slot_sc[ST_ID]  <= slot_sc[ST_IF];
      // Stamp is the counter value during the first IF cycle,
      // which is the value after this edge
      slot_tag[ST_IF] <= fetch_tag;
      slot_fc[ST_IF]  <= cycle_cnt + 1'b1;
      slot_sc[ST_IF]  <= '0;
    end else if (hold) begin
      // Held instructions collect one stall cycle each
      if (slot_valid[ST_IF] && slot_sc[ST_IF] != '1) begin
        slot_sc[ST_IF] <= slot_sc[ST_IF] + 1'b1;
      end
      if (slot_valid[ST_ID] && slot_sc[ST_ID] != '1) begin
        slot_sc[ST_ID] <= slot_sc[ST_ID] + 1'b1;
      end
    end
    // On flush the front payload is left as is, the valid bits are gone
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////
  // Retire record straight from WB
  assign retire_valid       = slot_valid[ST_WB];
  assign retire_tag         = slot_tag[ST_WB];
  assign retire_fetch_cycle = slot_fc[ST_WB];
  assign retire_cycle       = cycle_cnt;        // Counter during the WB cycle
  assign retire_stall_cnt   = slot_sc[ST_WB];

  // Valid instructions lost to this flush, 0 to 2
  assign flush_kill_cnt = flush ? ({1'b0, slot_valid[ST_IF]} + {1'b0, slot_valid[ST_ID]})
                                : 2'd0;

  // Count of valid slots
  always_comb begin
    occupancy = '0;
    for (int s = ST_IF; s <= ST_WB; s++) begin
      occupancy = occupancy + occ_t'(slot_valid[s]);
    end
  end

endmodule

// ==== hw/retire_log.sv ====
// Show-ahead FIFO of retire records plus retired and flushed totals
// LOG_DEPTH must be a power of two, 2 or more
// A record arriving while full is dropped, even if a pop happens that cycle
// log_overflow is sticky until reset; the pipeline is never stalled
// Totals wrap at 2^16, retired_count also counts dropped records

`timescale 1ns/10ps

module retire_log import trace_pkg::*; #(
  parameter int LOG_DEPTH = LOG_DEPTH_DEF
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       retire_valid,        // Record offered this cycle
  input  tag_t       retire_tag,
  input  cycle_t     retire_fetch_cycle,
  input  cycle_t     retire_cycle,
  input  stall_cnt_t retire_stall_cnt,
  input  logic [1:0] flush_kill_cnt,
  input  logic       log_pop,             // Strobe, ignored when empty
  output logic       log_valid,
  output tag_t       log_tag,
  output cycle_t     log_fetch_cycle,
  output cycle_t     log_retire_cycle,
  output stall_cnt_t log_stall_cnt,
  output logic       log_overflow,
  output count_t     retired_count,
  output count_t     flushed_count
);

  localparam int PTR_W = $clog2(LOG_DEPTH);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  tag_t       tag_mem [LOG_DEPTH];
  cycle_t     fc_mem  [LOG_DEPTH];        // Fetch stamps
  cycle_t     rc_mem  [LOG_DEPTH];        // Retire stamps
  stall_cnt_t sc_mem  [LOG_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fill;                 // 0 to LOG_DEPTH
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full      = (fill == (PTR_W+1)'(LOG_DEPTH));
  assign log_valid = (fill != '0);
  assign do_wr     = retire_valid && !full;
  assign do_rd     = log_pop && log_valid;

  // Write port, no reset on the array
  always_ff @(posedge clk) begin
    if (do_wr) begin
      tag_mem[wr_ptr] <= retire_tag;
      fc_mem[wr_ptr]  <= retire_fetch_cycle;
      rc_mem[wr_ptr]  <= retire_cycle;
      sc_mem[wr_ptr]  <= retire_stall_cnt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers, fill level and overflow
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fill         <= '0;
      log_overflow <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;     // Wraps on power-of-two depth
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;               // Both or neither
      endcase
      if (retire_valid && full) begin
        log_overflow <= 1'b1;                // Record lost, stays set
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Totals
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retired_count <= '0;
      flushed_count <= '0;
    end else begin
      if (retire_valid) begin
        retired_count <= retired_count + 1'b1;   // Every attempt
      end
      flushed_count <= flushed_count + count_t'(flush_kill_cnt);
    end
  end

  // Oldest record, shown ahead of the pop
  assign log_tag          = tag_mem[rd_ptr];
  assign log_fetch_cycle  = fc_mem[rd_ptr];
  assign log_retire_cycle = rc_mem[rd_ptr];
  assign log_stall_cnt    = sc_mem[rd_ptr];

endmodule

// ==== hw/pipe_trace_top.sv ====
// Pipeline tracer top, stage tracker feeding the retire log
// LOG_DEPTH sets the log size and must be a power of two, 2 or more
// Records show up on the log outputs the cycle after their WB cycle

`timescale 1ns/10ps

module pipe_trace_top import trace_pkg::*; #(
  parameter int LOG_DEPTH = LOG_DEPTH_DEF
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_valid,
  input  tag_t       fetch_tag,
  input  logic       stall,
  input  logic       flush,
  input  logic       log_pop,
  output logic       log_valid,
  output tag_t       log_tag,
  output cycle_t     log_fetch_cycle,
  output cycle_t     log_retire_cycle,
  output stall_cnt_t log_stall_cnt,
  output logic       log_overflow,
  output count_t     retired_count,
  output count_t     flushed_count,
  output occ_t       occupancy
);

  ////////////////////////////////////////////////////////////
  // Tracker to log
  ////////////////////////////////////////////////////////////
  logic       retire_valid;
  tag_t       retire_tag;
  cycle_t     retire_fetch_cycle;
  cycle_t     retire_cycle;
  stall_cnt_t retire_stall_cnt;
  logic [1:0] flush_kill_cnt;

  stage_tracker stage_tracker_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_valid        (fetch_valid),
    .fetch_tag          (fetch_tag),
    .stall              (stall),
    .flush              (flush),
    .occupancy          (occupancy),
    .retire_valid       (retire_valid),
    .retire_tag         (retire_tag),
    .retire_fetch_cycle (retire_fetch_cycle),
    .retire_cycle       (retire_cycle),
    .retire_stall_cnt   (retire_stall_cnt),
    .flush_kill_cnt     (flush_kill_cnt)
  );

  retire_log #(
    .LOG_DEPTH (LOG_DEPTH)
  ) retire_log_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .retire_valid       (retire_valid),
    .retire_tag         (retire_tag),
    .retire_fetch_cycle (retire_fetch_cycle),
    .retire_cycle       (retire_cycle),
    .retire_stall_cnt   (retire_stall_cnt),
    .flush_kill_cnt     (flush_kill_cnt),
    .log_pop            (log_pop),
    .log_valid          (log_valid),
    .log_tag            (log_tag),
    .log_fetch_cycle    (log_fetch_cycle),
    .log_retire_cycle   (log_retire_cycle),
    .log_stall_cnt      (log_stall_cnt),
    .log_overflow       (log_overflow),
    .retired_count      (retired_count),
    .flushed_count      (flushed_count)
  );

endmodule

// ==== tb/trace_ref.svh ====
// Software model of the tracer, stepped once per rising edge out of reset
// Include inside a module that imports trace_pkg and defines LOG_DEPTH
// Payload of empty slots is don't care and never compared

`ifndef TRACE_REF_SVH
`define TRACE_REF_SVH

typedef struct packed {
  tag_t       tag;
  cycle_t     fetch_cycle;
  cycle_t     retire_cycle;
  stall_cnt_t stall_cnt;
} rec_t;

logic       m_valid [5];                // Indexed by stage_t
tag_t       m_tag   [5];
cycle_t     m_fc    [5];                // Fetch stamps
stall_cnt_t m_sc    [5];                // Stall cycles, saturating
cycle_t     m_cyc;                      // Copy of the cycle counter
rec_t       m_log   [$];                // Expected log, oldest first
logic       m_overflow;
count_t     m_retired;
count_t     m_flushed;

function automatic void reset_model();
  foreach (m_valid[s]) begin
    m_valid[s] = 1'b0;
  end
  m_cyc      = '0;
  m_log.delete();
  m_overflow = 1'b0;
  m_retired  = '0;
  m_flushed  = '0;
endfunction

function automatic occ_t count_valid_slots();
  occ_t n;
  n = '0;
  foreach (m_valid[s]) begin
    n = n + occ_t'(m_valid[s]);
  end
  return n;
endfunction

function automatic void move_slot(stage_t dst, stage_t src);
  m_valid[dst] = m_valid[src];
  m_tag[dst]   = m_tag[src];
  m_fc[dst]    = m_fc[src];
  m_sc[dst]    = m_sc[src];
endfunction

// One rising edge with the inputs that were held during the cycle before it
function automatic void step_model(logic fv, tag_t ft, logic st, logic fl, logic pop);
  rec_t rec;
  logic wr;
  wr               = m_valid[ST_WB] && (m_log.size() < LOG_DEPTH);  // Fill before the edge
  rec.tag          = m_tag[ST_WB];
  rec.fetch_cycle  = m_fc[ST_WB];
  rec.retire_cycle = m_cyc;             // Counter during the WB cycle
  rec.stall_cnt    = m_sc[ST_WB];
  if (m_valid[ST_WB]) begin
    m_retired = m_retired + 1'b1;       // Dropped records count too
    if (!wr) begin
      m_overflow = 1'b1;
    end
  end
  if (fl) begin
    m_flushed = m_flushed + count_t'(m_valid[ST_IF]) + count_t'(m_valid[ST_ID]);
  end
  if (pop && m_log.size() != 0) begin
    m_log.delete(0);                    // Pop on empty is ignored
  end
  if (wr) begin
    m_log.push_back(rec);
  end
  // Back end first, so each slot reads its old upstream neighbour
  move_slot(ST_WB, ST_MEM);
  move_slot(ST_MEM, ST_EX);
  if (fl) begin
    m_valid[ST_IF] = 1'b0;              // Flush beats stall and fetch
    m_valid[ST_ID] = 1'b0;
    m_valid[ST_EX] = 1'b0;
  end else if (st) begin
    m_valid[ST_EX] = 1'b0;
    for (int s = ST_IF; s <= ST_ID; s++) begin
      if (m_valid[s] && m_sc[s] != '1) begin
        m_sc[s] = m_sc[s] + 1'b1;
      end
    end
  end else begin
    move_slot(ST_EX, ST_ID);
    move_slot(ST_ID, ST_IF);
    m_valid[ST_IF] = fv;
    m_tag[ST_IF]   = ft;
    m_fc[ST_IF]    = m_cyc + 1'b1;     // Counter value in the first IF cycle
    m_sc[ST_IF]    = '0;
  end
  m_cyc = m_cyc + 1'b1;
endfunction

`endif

// ==== tb/pipe_trace_tb.sv ====
// Testbench for the pipeline tracer with random fetch, stall, flush and pop
// Fixed seed, so every run drives the same stimulus
// Model steps at the rising edge, checks run at the falling edge
// Stops at the first mismatch

`timescale 1ns/10ps

module pipe_trace_tb import trace_pkg::*; ();

  localparam int LOG_DEPTH = LOG_DEPTH_DEF;
  localparam int TIMEOUT   = 200;       // Cycles any wait may take

  logic       clk;
  logic       rst_n;
  logic       fetch_valid;
  tag_t       fetch_tag;
  logic       stall;
  logic       flush;
  logic       log_pop;
  logic       log_valid;
  tag_t       log_tag;
  cycle_t     log_fetch_cycle;
  cycle_t     log_retire_cycle;
  stall_cnt_t log_stall_cnt;
  logic       log_overflow;
  count_t     retired_count;
  count_t     flushed_count;
  occ_t       occupancy;

  integer seed = 24;
  tag_t   next_tag;                     // Tags handed out in order
  int     waited;

  `include "trace_ref.svh"

  pipe_trace_top #(.LOG_DEPTH(LOG_DEPTH)) pipe_trace_top_i (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;                 // 8 ns period

  ////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  ////////////////////////////////////////////////////////////
  task automatic error_stop(string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_tag(tag_t got, tag_t exp, string what);
    if (got !== exp) begin
      error_stop($sformatf("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic check_cycle(cycle_t got, cycle_t exp, string what);
    if (got !== exp) begin
      error_stop($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_stall(stall_cnt_t got, stall_cnt_t exp, string what);
    if (got !== exp) begin
      error_stop($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_count(count_t got, count_t exp, string what);
    if (got !== exp) begin
      error_stop($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_occ(occ_t got, occ_t exp, string what);
    if (got !== exp) begin
      error_stop($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      error_stop($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // Record about to be popped against the model's oldest entry
  task automatic compare_record(rec_t exp);
    check_tag(log_tag, exp.tag, "log_tag");   // Killed tags would break the order here
    check_cycle(log_fetch_cycle, exp.fetch_cycle, "log_fetch_cycle");
    check_cycle(log_retire_cycle, exp.retire_cycle, "log_retire_cycle");
    check_stall(log_stall_cnt, exp.stall_cnt, "log_stall_cnt");
    if (exp.stall_cnt != '1) begin      // Latency rule only holds below saturation
      check_cycle(log_retire_cycle - log_fetch_cycle, cycle_t'(4 + exp.stall_cnt),
                  "retire minus fetch cycle");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model and check processes
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      step_model(fetch_valid, fetch_tag, stall, flush, log_pop);
    end
  end

  always @(negedge clk) begin           // Inputs and outputs both settled here
    if (rst_n) begin
      check_occ(occupancy, count_valid_slots(), "occupancy");
      check_flag(log_valid, m_log.size() != 0, "log_valid");
      check_flag(log_overflow, m_overflow, "log_overflow");
      check_count(retired_count, m_retired, "retired_count");
      check_count(flushed_count, m_flushed, "flushed_count");
      if (log_pop && m_log.size() != 0) begin
        compare_record(m_log[0]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  function automatic int roll_percent();
    int unsigned r;
    r = $random(seed);
    return int'(r % 100);
  endfunction

  // Random inputs for n cycles, each given as a percentage of high cycles
  task automatic drive_cycles(int n, int fetch_pct, int stall_pct, int flush_pct, int pop_pct);
    repeat (n) begin
      @(posedge clk);
      #1;
      fetch_valid = roll_percent() < fetch_pct;
      fetch_tag   = next_tag;
      if (fetch_valid) begin
        next_tag = next_tag + 1'b1;     // Tag lost if a stall or flush rejects it
      end
      stall   = roll_percent() < stall_pct;
      flush   = roll_percent() < flush_pct;
      log_pop = roll_percent() < pop_pct;
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch_tag   = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    log_pop     = 1'b0;
    next_tag    = '0;
    reset_model();
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    drive_cycles(4, 0, 0, 0, 100);      // Pops on the empty log
    drive_cycles(60, 80, 0, 0, 100);    // Clean flow
    drive_cycles(150, 80, 20, 5, 70);
    drive_cycles(60, 80, 20, 5, 0);     // No pops, log fills and overflows
    if (!m_overflow) begin
      error_stop("Log never overflowed during the phase without pops");
    end
    drive_cycles(150, 80, 20, 5, 70);
    if (m_flushed == 0) begin
      error_stop("No valid instruction was killed by a flush");
    end
    // Drain pipeline and log
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
    stall       = 1'b0;
    flush       = 1'b0;
    log_pop     = 1'b1;
    waited      = 0;
    while (m_log.size() != 0 || count_valid_slots() != 0 || log_valid) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > TIMEOUT) begin
        error_stop("Timeout while waiting for the log to drain");
      end
    end
    @(negedge clk);                     // Last round of checks
    #1;
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+tb
hw/trace_pkg.sv
hw/stage_tracker.sv
hw/retire_log.sv
hw/pipe_trace_top.sv
tb/pipe_trace_tb.sv

// ==== Bender.yml ====
package:
  name: pipe_trace

sources:
  # Package first, then the RTL bottom up
  - hw/trace_pkg.sv
  - hw/stage_tracker.sv
  - hw/retire_log.sv
  - hw/pipe_trace_top.sv
  # Testbench, its header lives in tb
  - target: test
    include_dirs:
      - tb
    files:
      - tb/pipe_trace_tb.sv
